// ==== design/ghrd_pkg.sv ====
// shared widths, timing constants and the trace event word for the fabric glue, import per module
package ghrd_pkg;

  // ==========================================================================
  // board and hps port widths
  // ==========================================================================

  localparam int unsigned key_count       = 2;   // push keys, active low
  localparam int unsigned sw_width        = 4;   // slide switches
  localparam int unsigned led_pio_width   = 7;   // led bits owned by the hps pio
  localparam int unsigned led_width       = 8;   // board led bus, bit 0 is heartbeat

  // reset request lines from the debug source
  // index 0 cold, 1 warm, 2 debug
  localparam int unsigned reset_req_count = 3;

  // hps stm hardware event input
  localparam int unsigned stm_width       = 28;
  localparam int unsigned stm_pad_width   = 15;  // unused top bits, tied low

  // ==========================================================================
  // timing constants, all in fpga_clk_50 cycles
  // ==========================================================================

  // key must hold steady this long before a change is taken
  localparam int unsigned debounce_timeout     = 50000;  // 1 ms at 50 MHz
  localparam int unsigned debounce_count_width = 16;     // holds debounce_timeout

  // reset request pulse widths
  localparam int unsigned cold_pulse_cycles  = 6;
  localparam int unsigned warm_pulse_cycles  = 2;
  localparam int unsigned debug_pulse_cycles = 32;

  // down counter in the pulse extender
  // 6 bits covers widths up to 64 since the counter loads width minus one
  localparam int unsigned pulse_count_width  = 6;

  // heartbeat toggles once per half period
  localparam int unsigned heartbeat_half_period = 25000000;  // 0.5 s at 50 MHz

  // ==========================================================================
  // trace event word
  // ==========================================================================

  // the fabric fills the fields, the stm port takes the raw word
  // field order from msb down matches the hps event bit map
  typedef union packed {
    logic [stm_width-1:0] raw;           // word as the trace unit sees it
    struct packed {
      logic [stm_pad_width-1:0] pad;     // always zero
      logic [sw_width-1:0]      sw;      // switch levels as sampled
      logic [led_pio_width-1:0] led_pio; // led pio value from the hps
      logic [key_count-1:0]     keys;    // debounced keys, low when pressed
    } fields;
  } stm_events_u;

  // 15 + 4 + 7 + 2 bits
  // the struct must fill the raw view exactly for the union to be legal

endpackage

// ==== design/key_debounce.sv ====
// key synchroniser and debounce filter, one stability counter per key, instantiated by ghrd_fabric
`timescale 1ns/1ps

module key_debounce #(
  parameter int unsigned timeout = ghrd_pkg::debounce_timeout  // stable cycles to accept
) (
  input  logic                           fpga_clk_50,
  input  logic                           hps_fpga_reset_n,
  input  logic [ghrd_pkg::key_count-1:0] key,             // raw keys, async
  output logic [ghrd_pkg::key_count-1:0] debounced_keys   // clean keys, low = pressed
);
  import ghrd_pkg::*;

  // counter value on the last stable cycle before the output follows
  localparam logic [debounce_count_width-1:0] count_last =
    debounce_count_width'(timeout - 1);

  logic [key_count-1:0]            key_meta;    // first sync stage
  logic [key_count-1:0]            key_sync;    // second sync stage, safe to use
  logic [debounce_count_width-1:0] stable_count [key_count];

  // ==========================================================================
  // two flop synchroniser
  // ==========================================================================

  // idle level of the keys is high
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      key_meta <= '1;
      key_sync <= '1;
    end
    else
    begin
      key_meta <= key;
      key_sync <= key_meta;
    end
  end

  // ==========================================================================
  // stability counters
  // ==========================================================================

  // a key only differs from its output while a change is pending
  // any bounce back to the old level clears the count at once
  // so a glitch shorter than timeout never reaches the output
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      for (int i = 0; i < key_count; i++)
      begin
        stable_count[i] <= '0;
      end
      debounced_keys <= '1;                         // released
    end
    else
    begin
      for (int i = 0; i < key_count; i++)
      begin
        if (key_sync[i] == debounced_keys[i])
        begin
          stable_count[i] <= '0;                    // nothing pending
        end
        else if (stable_count[i] == count_last)
        begin
          stable_count[i]   <= '0;
          debounced_keys[i] <= key_sync[i];         // held long enough, take it
        end
        else
        begin
          stable_count[i] <= stable_count[i] + 1'b1;
        end
      end
    end
  end

  // latency from a clean edge on key is timeout + 2 cycles
  // two for the synchroniser and timeout for the count

endmodule

// ==== design/reset_pulse_extender.sv ====
// rising edge detector that stretches one reset request into a fixed width active low pulse
`timescale 1ns/1ps

module reset_pulse_extender #(
  parameter int unsigned pulse_cycles = 1  // output low time, 1 up to 64
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  input  logic request,       // level from the debug source, active high
  output logic reset_req_n    // request to the hps, active low
);
  import ghrd_pkg::*;

  // busy runs for pulse_cycles, so the counter starts one lower
  localparam logic [pulse_count_width-1:0] count_load =
    pulse_count_width'(pulse_cycles - 1);

  logic                         req_q;    // request one cycle ago
  logic                         rise;     // low to high seen this cycle
  logic                         busy;     // pulse in progress
  logic [pulse_count_width-1:0] count;    // cycles left in the pulse

  assign rise = request & ~req_q;

  // ==========================================================================
  // edge detect and pulse counter
  // ==========================================================================

  // edge at clock n sets busy, output follows busy at clock n+1
  // a new edge is only taken when busy is clear and the output is back high
  // so nothing can stretch or retrigger a pulse that is still running
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      req_q       <= 1'b0;
      busy        <= 1'b0;
      count       <= '0;
      reset_req_n <= 1'b1;                 // no request out of reset
    end
    else
    begin
      req_q       <= request;
      reset_req_n <= ~busy;                // registered, one cycle behind busy

      if (busy)
      begin
        if (count == '0)
        begin
          busy <= 1'b0;                    // last cycle of the pulse
        end
        else
        begin
          count <= count - 1'b1;
        end
      end
      else if (rise && reset_req_n)
      begin
        busy  <= 1'b1;                     // start a new pulse
        count <= count_load;
      end
    end
  end

  // busy is high for pulse_cycles clocks
  // reset_req_n is low for the same count one clock later
  // request rising after edge 0 shows low from edge 2

endmodule

// ==== design/heartbeat_led.sv ====
// free running divider toggling the heartbeat led every half period, shows clock and reset alive
`timescale 1ns/1ps

module heartbeat_led #(
  parameter int unsigned half_period = ghrd_pkg::heartbeat_half_period  // cycles per toggle
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  output logic heartbeat          // to led 0
);

  // just wide enough for half_period - 1
  localparam int unsigned count_width = (half_period > 1) ? $clog2(half_period) : 1;
  localparam logic [count_width-1:0] count_wrap = count_width'(half_period - 1);

  logic [count_width-1:0] count;

  // ==========================================================================
  // divider
  // ==========================================================================

  // count runs 0 .. half_period - 1 and flips the led on each wrap
  // first rise lands half_period clocks after reset release
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      count     <= '0;
      heartbeat <= 1'b0;                   // led off out of reset
    end
    else if (count == count_wrap)
    begin
      count     <= '0;
      heartbeat <= ~heartbeat;             // half period done
    end
    else
    begin
      count <= count + 1'b1;
    end
  end

  // 25 bits at the default half period
  // full led period is two half periods, 1 s on the board

endmodule

// ==== design/ghrd_fabric.sv ====
// fabric glue top beside the hps, key debounce, reset request pulses, heartbeat and stm events
`timescale 1ns/1ps

module ghrd_fabric #(
  parameter int unsigned debounce_cycles  = ghrd_pkg::debounce_timeout,      // key settle time
  parameter int unsigned heartbeat_cycles = ghrd_pkg::heartbeat_half_period  // led half period
) (
  input  logic                                 fpga_clk_50,
  input  logic                                 hps_fpga_reset_n,
  input  logic [ghrd_pkg::key_count-1:0]       key,               // push keys, active low
  input  logic [ghrd_pkg::sw_width-1:0]        sw,                // slide switches
  input  logic [ghrd_pkg::led_pio_width-1:0]   led_pio,           // led pio from the hps
  input  logic [ghrd_pkg::reset_req_count-1:0] reset_req,         // 0 cold, 1 warm, 2 debug
  output logic [ghrd_pkg::led_width-1:0]       led,               // board leds
  output logic [ghrd_pkg::key_count-1:0]       debounced_keys,    // to the button pio
  output logic [ghrd_pkg::stm_width-1:0]       stm_hw_events,     // to the hps stm port
  output logic                                 cold_reset_req_n,
  output logic                                 warm_reset_req_n,
  output logic                                 debug_reset_req_n
);
  import ghrd_pkg::*;

  logic        heartbeat;    // divider output for led 0
  stm_events_u stm_events;   // event word, written by field

  // ==========================================================================
  // key debounce
  // ==========================================================================

  key_debounce #(
    .timeout          (debounce_cycles)
  ) i_key_debounce (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key              (key),
    .debounced_keys   (debounced_keys)
  );

  // ==========================================================================
  // reset request pulses
  // ==========================================================================

  // one extender per request line, widths fixed by the hps reset manager
  reset_pulse_extender #(
    .pulse_cycles     (cold_pulse_cycles)
  ) i_cold_reset_pulse (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .request          (reset_req[0]),
    .reset_req_n      (cold_reset_req_n)
  );

  reset_pulse_extender #(
    .pulse_cycles     (warm_pulse_cycles)
  ) i_warm_reset_pulse (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .request          (reset_req[1]),
    .reset_req_n      (warm_reset_req_n)
  );

  reset_pulse_extender #(
    .pulse_cycles     (debug_pulse_cycles)
  ) i_debug_reset_pulse (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .request          (reset_req[2]),
    .reset_req_n      (debug_reset_req_n)
  );

  // ==========================================================================
  // heartbeat and led bus
  // ==========================================================================

  heartbeat_led #(
    .half_period      (heartbeat_cycles)
  ) i_heartbeat_led (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .heartbeat        (heartbeat)
  );

  assign led = {led_pio, heartbeat};   // pio on the upper seven, heartbeat on led 0

  // ==========================================================================
  // stm hardware event word
  // ==========================================================================

  // fields go in by name, the trace unit gets the flat word
  always_comb
  begin
    stm_events.fields.pad     = '0;
    stm_events.fields.sw      = sw;
    stm_events.fields.led_pio = led_pio;
    stm_events.fields.keys    = debounced_keys;   // registered in key_debounce
  end

  assign stm_hw_events = stm_events.raw;

endmodule

// ==== test/tb_ghrd_fabric.sv ====
// self-checking testbench for ghrd_fabric, run with the file list at the project root
`timescale 1ns/1ps

module tb_ghrd_fabric;
  import ghrd_pkg::*;

  localparam int unsigned debounce_len    = 20;   // short settle time for simulation
  localparam int unsigned half_period_len = 50;   // short heartbeat half period

  // phase lengths in clock cycles, used for the run limit
  localparam int unsigned reset_phase     = 4 + 2;
  localparam int unsigned bus_phase       = 50;
  localparam int unsigned glitch_phase    = 2 * 2 * 4 * (19 + 25);  // states x keys x glitches
  localparam int unsigned edge_phase      = 4 * (23 + 1);
  localparam int unsigned pulse_phase     = 3 * (8 + 2 + 32 + 10 + 3);
  localparam int unsigned heartbeat_phase = 11 * half_period_len;
  localparam int unsigned max_cycles      = 2 * (reset_phase + bus_phase + glitch_phase +
                                                 edge_phase + pulse_phase + heartbeat_phase);

  logic                       fpga_clk_50;
  logic                       hps_fpga_reset_n;
  logic [key_count-1:0]       key;
  logic [sw_width-1:0]        sw;
  logic [led_pio_width-1:0]   led_pio;
  logic [reset_req_count-1:0] reset_req;
  logic [led_width-1:0]       led;
  logic [key_count-1:0]       debounced_keys;
  logic [stm_width-1:0]       stm_hw_events;
  logic                       cold_reset_req_n;
  logic                       warm_reset_req_n;
  logic                       debug_reset_req_n;

  logic [key_count-1:0]       exp_keys;      // expected debounced level
  logic [reset_req_count-1:0] exp_reset_n;   // expected request outputs, index as reset_req
  logic                       keys_moving;   // debounce window open, key checks held off
  logic [31:0]                lfsr_state = 32'h95cf_cecf;
  int unsigned                hb_edges = 0;     // clock edges since reset release
  int unsigned                cycle_count = 0;

  ghrd_fabric #(
    .debounce_cycles   (debounce_len),
    .heartbeat_cycles  (half_period_len)
  ) i_ghrd_fabric (
    .fpga_clk_50       (fpga_clk_50),
    .hps_fpga_reset_n  (hps_fpga_reset_n),
    .key               (key),
    .sw                (sw),
    .led_pio           (led_pio),
    .reset_req         (reset_req),
    .led               (led),
    .debounced_keys    (debounced_keys),
    .stm_hw_events     (stm_hw_events),
    .cold_reset_req_n  (cold_reset_req_n),
    .warm_reset_req_n  (warm_reset_req_n),
    .debug_reset_req_n (debug_reset_req_n)
  );

  always #20 fpga_clk_50 = ~fpga_clk_50;   // 40 ns period

  // ==========================================================================
  // reference models and helpers
  // ==========================================================================

  // x^32 + x^22 + x^2 + x + 1, shift left
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      val        = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  function automatic logic [stm_width-1:0] pack_event_word(
    input logic [sw_width-1:0]      sw_v,
    input logic [led_pio_width-1:0] pio_v,
    input logic [key_count-1:0]     keys_v
  );
    stm_events_u word;
    word.fields.pad     = '0;   // top bits tied low
    word.fields.sw      = sw_v;
    word.fields.led_pio = pio_v;
    word.fields.keys    = keys_v;
    return word.raw;
  endfunction

  function automatic logic [led_width-1:0] led_bus_model(
    input logic [led_pio_width-1:0] pio_v,
    input logic                     hb_v
  );
    return {pio_v, hb_v};
  endfunction

  // led toggles on every half period edge count since release
  function automatic logic heartbeat_level(input int unsigned edges);
    return 1'((edges / half_period_len) % 2);
  endfunction

  function automatic int unsigned pulse_width_for(input int unsigned idx);
    case (idx)
      0:       return 6;    // cold
      1:       return 2;    // warm
      default: return 32;   // debug
    endcase
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected)
    begin
      abort_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  task automatic wait_drive_slot();
    @(posedge fpga_clk_50);
    #2;                                   // inputs move just after the edge
  endtask

  // ==========================================================================
  // compare process, outputs are stable at the falling edge
  // ==========================================================================

  always @(posedge fpga_clk_50)
  begin
    if (hps_fpga_reset_n)
    begin
      hb_edges <= hb_edges + 1;
    end
  end

  always @(negedge fpga_clk_50)
  begin
    compare_value("cold_reset_req_n", 32'(cold_reset_req_n), 32'(exp_reset_n[0]));
    compare_value("warm_reset_req_n", 32'(warm_reset_req_n), 32'(exp_reset_n[1]));
    compare_value("debug_reset_req_n", 32'(debug_reset_req_n), 32'(exp_reset_n[2]));
    compare_value("led", 32'(led), 32'(led_bus_model(led_pio, heartbeat_level(hb_edges))));
    if (!keys_moving)
    begin
      compare_value("debounced_keys", 32'(debounced_keys), 32'(exp_keys));
      compare_value("stm_hw_events", 32'(stm_hw_events),
                    32'(pack_event_word(sw, led_pio, exp_keys)));
    end
  end

  always @(posedge fpga_clk_50)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles)
    begin
      abort_run($sformatf("test timed out after %0d cycles", cycle_count));
    end
  end

  // ==========================================================================
  // stimulus tasks
  // ==========================================================================

  // short flip away from the stable level, must never reach the output
  task automatic glitch_key(input int unsigned idx);
    int unsigned glen;
    glen     = 1 + (rand_bits(5) % (debounce_len - 1));   // 1 .. 19
    key[idx] = ~exp_keys[idx];
    repeat (glen) wait_drive_slot();
    key[idx] = exp_keys[idx];
    repeat (25) wait_drive_slot();
  endtask

  // held change, output must follow 20 to 23 edges later
  task automatic debounce_edge(input int unsigned idx, input logic level);
    int unsigned n;
    keys_moving = 1'b1;
    key[idx]    = level;
    for (n = 1; n < debounce_len; n++)
    begin
      wait_drive_slot();
      compare_value("debounced_keys", 32'(debounced_keys), 32'(exp_keys));  // too early
    end
    while (n <= debounce_len + 3 && debounced_keys[idx] != level)
    begin
      wait_drive_slot();
      n++;
    end
    if (debounced_keys[idx] != level)
    begin
      abort_run($sformatf("debounced key %0d did not follow a held change in time", idx));
    end
    exp_keys[idx] = level;
    compare_value("debounced_keys", 32'(debounced_keys), 32'(exp_keys));
    keys_moving = 1'b0;
  endtask

  // pulse with a second rising edge inside it, which must be ignored
  task automatic pulse_test(input int unsigned idx);
    int unsigned gap;
    int unsigned width;
    gap   = 1 + rand_bits(3);
    width = pulse_width_for(idx);
    repeat (gap) wait_drive_slot();
    reset_req[idx] = 1'b1;               // rises after edge k
    wait_drive_slot();
    reset_req[idx] = 1'b0;
    wait_drive_slot();                   // edge k+2, output now low
    exp_reset_n[idx] = 1'b0;
    reset_req[idx]   = 1'b1;             // second edge during the pulse
    repeat (width) wait_drive_slot();
    exp_reset_n[idx] = 1'b1;             // back high at edge k+2+width
    repeat (10) wait_drive_slot();       // no retrigger
    reset_req[idx] = 1'b0;
    repeat (3) wait_drive_slot();
  endtask

  // ==========================================================================
  // test sequence
  // ==========================================================================

  initial
  begin
    int unsigned toggles;
    logic        last_led0;
    fpga_clk_50      = 1'b0;
    hps_fpga_reset_n = 1'b0;
    key              = '1;               // released
    sw               = '0;
    led_pio          = '0;
    reset_req        = '0;
    exp_keys         = '1;
    exp_reset_n      = '1;
    keys_moving      = 1'b0;

    repeat (4) @(posedge fpga_clk_50);
    #2;
    hps_fpga_reset_n = 1'b1;
    wait_drive_slot();

    // reset state
    compare_value("cold_reset_req_n", 32'(cold_reset_req_n), 32'h1);
    compare_value("warm_reset_req_n", 32'(warm_reset_req_n), 32'h1);
    compare_value("debug_reset_req_n", 32'(debug_reset_req_n), 32'h1);
    compare_value("debounced_keys", 32'(debounced_keys), 32'h3);
    compare_value("led[0]", 32'(led[0]), 32'h0);

    // event word and led bus, checked by the compare process
    repeat (50)
    begin
      sw      = sw_width'(rand_bits(sw_width));
      led_pio = led_pio_width'(rand_bits(led_pio_width));
      wait_drive_slot();
    end

    // debounce, glitches from released, presses, glitches from pressed, releases
    for (int k = 0; k < key_count; k++)
    begin
      repeat (4) glitch_key(k);
    end
    debounce_edge(0, 1'b0);
    debounce_edge(1, 1'b0);
    for (int k = 0; k < key_count; k++)
    begin
      repeat (4) glitch_key(k);
    end
    debounce_edge(0, 1'b1);
    debounce_edge(1, 1'b1);

    // reset request pulses
    for (int r = 0; r < reset_req_count; r++)
    begin
      pulse_test(r);
    end

    // heartbeat, exact level is checked every cycle
    toggles   = 0;
    last_led0 = led[0];
    while (toggles < 10)
    begin
      wait_drive_slot();
      if (led[0] !== last_led0)
      begin
        toggles++;
        last_led0 = led[0];
      end
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== ghrd_fabric.f ====
design/ghrd_pkg.sv
design/key_debounce.sv
design/reset_pulse_extender.sv
design/heartbeat_led.sv
design/ghrd_fabric.sv
test/tb_ghrd_fabric.sv

// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_ghrd_fabric
FILELIST   = ghrd_fabric.f
OBJ_DIR    = obj_dir
PASS_MSG   = *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the pass message in the output decides the exit status
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
